//--- dv/tb_lfsr.svh
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'd77;

// one step, returns the new bit
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// n fresh bits, lsb aligned
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val = {val[30:0], lfsr_bit()};
  end
  return val;
endfunction

// true in num out of four cases
function automatic logic quarter_chance(input int num);
  return rand_bits(2) < num;
endfunction

`endif

//--- dv/fabric_tb.sv
`default_nettype none

module fabric_tb;
  import fabric_pkg::*;

  localparam int N_TXN       = 300;
  localparam int CYCLE_LIMIT = N_TXN * 40;

  logic        cpu_clk_i = 1'b0;
  logic        rst_i;
  logic        cpu_req_valid_i;
  fab_req_t    cpu_req_i;
  logic        cpu_req_ready_o;
  logic        cpu_rsp_valid_o;
  fab_rsp_t    cpu_rsp_o;
  logic        cpu_rsp_ready_i;
  logic        dma_req_valid_i;
  narrow_req_t dma_req_i;
  logic        dma_req_ready_o;
  logic        dma_rsp_valid_o;
  narrow_rsp_t dma_rsp_o;
  logic        dma_rsp_ready_i;
  logic        mem_req_valid_o;
  fab_req_t    mem_req_o;
  logic        mem_req_ready_i;
  logic        mem_rsp_valid_i;
  fab_rsp_t    mem_rsp_i;
  logic        mem_rsp_ready_o;
  logic        reg_req_valid_o;
  reg_req_t    reg_req_o;
  logic        reg_req_ready_i;
  logic        reg_rsp_valid_i;
  narrow_rsp_t reg_rsp_i;
  logic        reg_rsp_ready_o;

  // reference images and target images
  logic [63:0] ref_mem [logic [28:0]];
  logic [63:0] tgt_mem [logic [28:0]];
  logic [31:0] ref_regs [256];
  logic [31:0] tgt_regs [256];

  fab_rsp_t    cpu_exp_q [$];
  narrow_rsp_t dma_exp_q [$];
  fab_rsp_t    mem_rsp_q [$];
  narrow_rsp_t reg_rsp_q [$];

  int   mem_wait = 0;
  int   reg_wait = 0;
  int   cpu_issued = 0;
  int   dma_issued = 0;
  int   cpu_seen = 0;
  int   dma_seen = 0;
  int   value_errs = 0;
  int   other_errs = 0;
  int   cycles = 0;
  logic cpu_pending = 1'b0;
  logic dma_pending = 1'b0;
  logic last_dma = 1'b0;
  logic both_held = 1'b0;

  `include "tb_lfsr.svh"

  soc_fabric_top dut_i (.*);

  always #10 cpu_clk_i = ~cpu_clk_i;

  always @(posedge cpu_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with transactions still open", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    $display("%0t: %s", $time, msg);
  endtask

  function automatic logic [63:0] mem_fill(input logic [28:0] key);
    return {key, 3'b101, ~key, 3'b010};
  endfunction

  function automatic logic mem_err(input logic [31:0] addr);
    return addr[31:28] == 4'hF;
  endfunction

  function automatic logic reg_err(input logic [7:0] idx);
    return idx[7:6] == 2'b11;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wd,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wd[8*b +: 8];
      end
    end
    return res;
  endfunction

  // dma request as it should look on the 64-bit side
  function automatic fab_req_t to_fabric(input narrow_req_t n);
    fab_req_t f;
    f.addr       = n.addr;
    f.write      = n.write;
    f.wdata.word = {n.wdata, n.wdata};
    f.wstrb      = n.addr[2] ? {n.wstrb, 4'h0} : {4'h0, n.wstrb};
    return f;
  endfunction

  // 64-bit request as it should look at the register port
  function automatic reg_req_t to_reg_port(input fab_req_t f);
    reg_req_t r;
    r.addr  = f.addr[7:0];
    r.write = f.write;
    r.wdata = f.addr[2] ? f.wdata.word[63:32] : f.wdata.word[31:0];
    r.wstrb = f.addr[2] ? f.wstrb[7:4] : f.wstrb[3:0];
    return r;
  endfunction

  // half register region, a few erroring memory accesses
  function automatic logic [31:0] random_addr();
    logic [3:0] region;
    logic [5:0] off;
    if (rand_bits(1) == 1) begin
      region = 4'h1;
    end else if (rand_bits(3) == 0) begin
      region = 4'hF;
    end else begin
      region = 4'h2;
    end
    off = 6'(rand_bits(6));
    return {region, 20'h0, off, 2'b00};
  endfunction

  // ----------------------------------------------------------
  // reference model, applied at master acceptance
  // ----------------------------------------------------------
  task automatic predict(input fab_req_t f, input logic from_dma);
    logic [28:0] key;
    logic [7:0]  idx;
    logic        hi;
    logic [63:0] rdata;
    logic        err;
    reg_req_t    lane_req;
    fab_rsp_t    rf;
    narrow_rsp_t rn;
    hi    = f.addr[LANE_BIT];
    rdata = '0;
    if (f.addr[31:28] == 4'h1) begin
      idx      = f.addr[7:0];
      err      = reg_err(idx);
      lane_req = to_reg_port(f);
      if (!err && f.write) begin
        ref_regs[idx] = 32'(merge_bytes({32'h0, ref_regs[idx]}, {32'h0, lane_req.wdata},
                                        {4'h0, lane_req.wstrb}));
      end else if (!err) begin
        rdata = hi ? {ref_regs[idx], 32'h0} : {32'h0, ref_regs[idx]};
      end
    end else begin
      key = f.addr[31:3];
      err = mem_err(f.addr);
      if (!ref_mem.exists(key)) begin
        ref_mem[key] = mem_fill(key);
      end
      if (!err && f.write) begin
        ref_mem[key] = merge_bytes(ref_mem[key], f.wdata.word, f.wstrb);
      end else if (!err) begin
        rdata = ref_mem[key];
      end
    end
    if (from_dma) begin
      rn.rdata = hi ? rdata[63:32] : rdata[31:0];
      rn.err   = err;
      dma_exp_q.push_back(rn);
    end else begin
      rf.rdata.word = rdata;
      rf.err        = err;
      cpu_exp_q.push_back(rf);
    end
  endtask

  // ----------------------------------------------------------
  // target models, answer in order after a random delay
  // ----------------------------------------------------------
  task automatic serve_mem(input fab_req_t r);
    fab_rsp_t    rsp;
    logic [28:0] key;
    key           = r.addr[31:3];
    rsp.err       = mem_err(r.addr);
    rsp.rdata.word = '0;
    if (!tgt_mem.exists(key)) begin
      tgt_mem[key] = mem_fill(key);
    end
    if (!rsp.err && r.write) begin
      tgt_mem[key] = merge_bytes(tgt_mem[key], r.wdata.word, r.wstrb);
    end else if (!rsp.err) begin
      rsp.rdata.word = tgt_mem[key];
    end
    if (mem_rsp_q.size() == 0) begin
      mem_wait = int'(rand_bits(2));
    end
    mem_rsp_q.push_back(rsp);
  endtask

  task automatic serve_reg(input reg_req_t r);
    narrow_rsp_t rsp;
    rsp.err   = reg_err(r.addr);
    rsp.rdata = '0;
    if (!rsp.err && r.write) begin
      tgt_regs[r.addr] = 32'(merge_bytes({32'h0, tgt_regs[r.addr]}, {32'h0, r.wdata},
                                         {4'h0, r.wstrb}));
    end else if (!rsp.err) begin
      rsp.rdata = tgt_regs[r.addr];
    end
    if (reg_rsp_q.size() == 0) begin
      reg_wait = int'(rand_bits(2));
    end
    reg_rsp_q.push_back(rsp);
  endtask

  // ----------------------------------------------------------
  // stimulus, 1 time unit after the rising edge
  // ----------------------------------------------------------
  task automatic drive_inputs();
    if (!cpu_pending && cpu_issued < N_TXN && quarter_chance(2)) begin
      cpu_req_i.addr       = random_addr();
      cpu_req_i.write      = 1'(rand_bits(1));
      cpu_req_i.wdata.word = {rand_bits(32), rand_bits(32)};
      cpu_req_i.wstrb      = 8'(rand_bits(8));
      cpu_pending          = 1'b1;
      cpu_issued++;
    end
    if (!dma_pending && dma_issued < N_TXN && quarter_chance(2)) begin
      dma_req_i.addr  = random_addr();
      dma_req_i.write = 1'(rand_bits(1));
      dma_req_i.wdata = rand_bits(32);
      dma_req_i.wstrb = 4'(rand_bits(4));
      dma_pending     = 1'b1;
      dma_issued++;
    end
    cpu_req_valid_i = cpu_pending;
    dma_req_valid_i = dma_pending;
    cpu_rsp_ready_i = quarter_chance(3);
    dma_rsp_ready_i = quarter_chance(3);
    mem_req_ready_i = quarter_chance(3);
    reg_req_ready_i = quarter_chance(3);
    if (mem_rsp_q.size() > 0 && mem_wait == 0) begin
      mem_rsp_valid_i = 1'b1;
      mem_rsp_i       = mem_rsp_q[0];
    end else begin
      mem_rsp_valid_i = 1'b0;
      if (mem_wait > 0) begin
        mem_wait--;
      end
    end
    if (reg_rsp_q.size() > 0 && reg_wait == 0) begin
      reg_rsp_valid_i = 1'b1;
      reg_rsp_i       = reg_rsp_q[0];
    end else begin
      reg_rsp_valid_i = 1'b0;
      if (reg_wait > 0) begin
        reg_wait--;
      end
    end
  endtask

  // ----------------------------------------------------------
  // monitor at the falling edge, values are settled here
  // ----------------------------------------------------------
  task automatic monitor_cycle();
    logic        dma_eff;
    logic        both_now;
    logic        cpu_x;
    logic        dma_x;
    logic        mem_x;
    logic        reg_x;
    logic        is_reg;
    fab_req_t    acc;
    fab_rsp_t    exp_f;
    narrow_rsp_t exp_n;
    // upsizer holds the dma back once its lane queue is full
    dma_eff  = dma_req_valid_i && (dma_exp_q.size() < MAX_OUTSTANDING);
    both_now = cpu_req_valid_i && dma_eff;

    if (cpu_exp_q.size() == 0) begin
      assert (!cpu_rsp_valid_o) else note_failure("cpu response valid with nothing outstanding");
    end else if (cpu_rsp_valid_o && cpu_rsp_ready_i) begin
      exp_f = cpu_exp_q.pop_front();
      check_value("cpu_rsp_o", 128'(cpu_rsp_o), 128'(exp_f));
      cpu_seen++;
    end
    if (dma_exp_q.size() == 0) begin
      assert (!dma_rsp_valid_o) else note_failure("dma response valid with nothing outstanding");
    end else if (dma_rsp_valid_o && dma_rsp_ready_i) begin
      exp_n = dma_exp_q.pop_front();
      check_value("dma_rsp_o", 128'(dma_rsp_o), 128'(exp_n));
      dma_seen++;
    end

    if (mem_rsp_valid_i && mem_rsp_ready_o) begin
      mem_rsp_q.delete(0);
      mem_wait = int'(rand_bits(2));
    end
    if (reg_rsp_valid_i && reg_rsp_ready_o) begin
      reg_rsp_q.delete(0);
      reg_wait = int'(rand_bits(2));
    end

    cpu_x  = cpu_req_valid_i && cpu_req_ready_o;
    dma_x  = dma_req_valid_i && dma_req_ready_o;
    mem_x  = mem_req_valid_o && mem_req_ready_i;
    reg_x  = reg_req_valid_o && reg_req_ready_i;
    acc    = dma_x ? to_fabric(dma_req_i) : cpu_req_i;
    is_reg = (acc.addr[31:28] == 4'h1);
    assert (!(cpu_x && dma_x)) else note_failure("both masters accepted in one cycle");
    assert (mem_x == ((cpu_x || dma_x) && !is_reg))
      else note_failure("memory port transfer does not match an accepted request");
    assert (reg_x == ((cpu_x || dma_x) && is_reg))
      else note_failure("register port transfer does not match an accepted request");
    if (mem_x) begin
      check_value("mem_req_o", 128'(mem_req_o), 128'(acc));
      serve_mem(mem_req_o);
    end
    if (reg_x) begin
      check_value("reg_req_o", 128'(reg_req_o), 128'(to_reg_port(acc)));
      serve_reg(reg_req_o);
    end

    // round robin across back to back contested grants
    if (cpu_x || dma_x) begin
      if (both_now && both_held) begin
        assert (dma_x != last_dma)
          else note_failure("same master granted twice while both were waiting");
      end
      last_dma  = dma_x;
      both_held = both_now;
      predict(acc, dma_x);
    end else if (!both_now) begin
      both_held = 1'b0;
    end
    if (cpu_x) begin
      cpu_pending = 1'b0;
    end
    if (dma_x) begin
      dma_pending = 1'b0;
    end
  endtask

  function automatic logic all_done();
    return cpu_issued == N_TXN && dma_issued == N_TXN && !cpu_pending && !dma_pending &&
           cpu_exp_q.size() == 0 && dma_exp_q.size() == 0 &&
           mem_rsp_q.size() == 0 && reg_rsp_q.size() == 0;
  endfunction

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    rst_i           = 1'b1;
    cpu_req_valid_i = 1'b0;
    cpu_req_i       = '0;
    cpu_rsp_ready_i = 1'b0;
    dma_req_valid_i = 1'b0;
    dma_req_i       = '0;
    dma_rsp_ready_i = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    reg_req_ready_i = 1'b0;
    reg_rsp_valid_i = 1'b0;
    reg_rsp_i       = '0;
    for (int i = 0; i < 256; i++) begin
      ref_regs[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5A, 8'hC3};
      tgt_regs[i] = ref_regs[i];
    end

    repeat (2) @(posedge cpu_clk_i);
    #1 rst_i = 1'b0;
    // stray target responses with every queue empty
    mem_rsp_valid_i = 1'b1;
    reg_rsp_valid_i = 1'b1;
    cpu_rsp_ready_i = 1'b1;
    dma_rsp_ready_i = 1'b1;
    @(negedge cpu_clk_i);
    assert (!mem_req_valid_o && !reg_req_valid_o && !cpu_rsp_valid_o && !dma_rsp_valid_o)
      else note_failure("a valid output is high right after reset");
    assert (!mem_rsp_ready_o && !reg_rsp_ready_o)
      else note_failure("a target response is taken right after reset");

    while (!all_done()) begin
      @(posedge cpu_clk_i);
      #1 drive_inputs();
      @(negedge cpu_clk_i);
      monitor_cycle();
    end

    // quiet tail, stray target responses must not come back
    repeat (10) begin
      @(posedge cpu_clk_i);
      #1;
      cpu_req_valid_i = 1'b0;
      dma_req_valid_i = 1'b0;
      mem_rsp_valid_i = 1'b1;
      reg_rsp_valid_i = 1'b1;
      cpu_rsp_ready_i = 1'b1;
      dma_rsp_ready_i = 1'b1;
      @(negedge cpu_clk_i);
      assert (!cpu_rsp_valid_o && !dma_rsp_valid_o)
        else note_failure("response valid after the last response");
    end

    $display("errors: %0d value, %0d other; responses cpu %0d dma %0d",
             value_errs, other_errs, cpu_seen, dma_seen);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
src/fabric_pkg.sv
src/tag_fifo.sv
src/dma_upsizer.sv
src/master_arbiter.sv
src/target_router.sv
src/reg_downsizer.sv
src/soc_fabric_top.sv
dv/fabric_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fabric_tb -f filelist.f
./obj_dir/Vfabric_tb 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "run ended without a result, see sim.log"
  exit 1
fi

//--- src/dma_upsizer.sv
`default_nettype none

module dma_upsizer (
  input  logic                     cpu_clk_i,
  input  logic                     rst_i,
  input  logic                     dma_req_valid_i,
  input  fabric_pkg::narrow_req_t  dma_req_i,
  output logic                     dma_req_ready_o,
  output logic                     dma_rsp_valid_o,
  output fabric_pkg::narrow_rsp_t  dma_rsp_o,
  input  logic                     dma_rsp_ready_i,
  output logic                     up_req_valid_o,
  output fabric_pkg::fab_req_t     up_req_o,
  input  logic                     up_req_ready_i,
  input  logic                     up_rsp_valid_i,
  input  fabric_pkg::fab_rsp_t     up_rsp_i,
  output logic                     up_rsp_ready_o
);
  import fabric_pkg::*;

  logic lane_sel;
  logic head_lane;
  logic tag_empty;
  logic tag_full;

  assign lane_sel = dma_req_i.addr[LANE_BIT];

  // ----------------------------------------------------------
  // request path
  // ----------------------------------------------------------
  assign up_req_valid_o  = dma_req_valid_i && !tag_full;
  assign dma_req_ready_o = up_req_ready_i && !tag_full;

  // data goes to both lanes, strobes pick the real one
  always_comb begin
    up_req_o.addr          = dma_req_i.addr;
    up_req_o.write         = dma_req_i.write;
    up_req_o.wdata.lane[0] = dma_req_i.wdata;
    up_req_o.wdata.lane[1] = dma_req_i.wdata;
    if (lane_sel) begin
      up_req_o.wstrb = {dma_req_i.wstrb, {LANE_STRB_W{1'b0}}};
    end else begin
      up_req_o.wstrb = {{LANE_STRB_W{1'b0}}, dma_req_i.wstrb};
    end
  end

  // ----------------------------------------------------------
  // response path
  // ----------------------------------------------------------
  assign dma_rsp_valid_o = up_rsp_valid_i && !tag_empty;
  assign up_rsp_ready_o  = dma_rsp_ready_i && !tag_empty;
  assign dma_rsp_o.rdata = up_rsp_i.rdata.lane[head_lane];
  assign dma_rsp_o.err   = up_rsp_i.err;

  // lane of each outstanding access
  tag_fifo lane_fifo_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .push_i     (up_req_valid_o && up_req_ready_i),
    .push_tag_i (lane_sel),
    .pop_i      (dma_rsp_valid_o && dma_rsp_ready_i),
    .head_tag_o (head_lane),
    .empty_o    (tag_empty),
    .full_o     (tag_full)
  );

endmodule

`default_nettype wire

//--- src/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

  // ----------------------------------------------------------
  // widths and address map
  // ----------------------------------------------------------
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 64;
  localparam int LANE_W      = 32;
  localparam int STRB_W      = 8;
  localparam int LANE_STRB_W = 4;
  localparam int LANE_BIT    = 2;
  localparam int REG_ADDR_W  = 8;

  // register target lives where addr[31:28] == 1
  localparam int             REGION_W   = 4;
  localparam logic [REGION_W-1:0] REG_REGION = 4'h1;

  // outstanding transaction tracking
  localparam int MAX_OUTSTANDING = 4;
  localparam int TAG_PTR_W       = $clog2(MAX_OUTSTANDING);
  localparam int TAG_CNT_W       = $clog2(MAX_OUTSTANDING + 1);

  // ----------------------------------------------------------
  // payload types
  // ----------------------------------------------------------
  typedef union packed {
    logic [DATA_W-1:0]      word;
    logic [1:0][LANE_W-1:0] lane;
  } bus_data_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    bus_data_u         wdata;
    logic [STRB_W-1:0] wstrb;
  } fab_req_t;

  typedef struct packed {
    bus_data_u rdata;
    logic      err;
  } fab_rsp_t;

  // dma side, 32-bit data with full address
  typedef struct packed {
    logic [ADDR_W-1:0]      addr;
    logic                   write;
    logic [LANE_W-1:0]      wdata;
    logic [LANE_STRB_W-1:0] wstrb;
  } narrow_req_t;

  // register port, address cut down
  typedef struct packed {
    logic [REG_ADDR_W-1:0]  addr;
    logic                   write;
    logic [LANE_W-1:0]      wdata;
    logic [LANE_STRB_W-1:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [LANE_W-1:0] rdata;
    logic              err;
  } narrow_rsp_t;

endpackage

`default_nettype wire

//--- src/master_arbiter.sv
`default_nettype none

module master_arbiter (
  input  logic                  cpu_clk_i,
  input  logic                  rst_i,
  input  logic                  m0_req_valid_i,
  input  fabric_pkg::fab_req_t  m0_req_i,
  output logic                  m0_req_ready_o,
  output logic                  m0_rsp_valid_o,
  output fabric_pkg::fab_rsp_t  m0_rsp_o,
  input  logic                  m0_rsp_ready_i,
  input  logic                  m1_req_valid_i,
  input  fabric_pkg::fab_req_t  m1_req_i,
  output logic                  m1_req_ready_o,
  output logic                  m1_rsp_valid_o,
  output fabric_pkg::fab_rsp_t  m1_rsp_o,
  input  logic                  m1_rsp_ready_i,
  output logic                  dn_req_valid_o,
  output fabric_pkg::fab_req_t  dn_req_o,
  input  logic                  dn_req_ready_i,
  input  logic                  dn_rsp_valid_i,
  input  fabric_pkg::fab_rsp_t  dn_rsp_i,
  output logic                  dn_rsp_ready_o
);

  logic sel;
  logic locked_q;
  logic grant_q;
  logic last_q;
  logic dn_xfer;
  logic owner;
  logic tag_empty;
  logic tag_full;

  // ----------------------------------------------------------
  // grant selection
  // ----------------------------------------------------------
  // a stalled grant is held, a tie goes to the other master
  always_comb begin
    if (locked_q) begin
      sel = grant_q;
    end else if (m0_req_valid_i && m1_req_valid_i) begin
      sel = ~last_q;
    end else begin
      sel = m1_req_valid_i;
    end
  end

  assign dn_req_valid_o = !tag_full && (sel ? m1_req_valid_i : m0_req_valid_i);
  assign dn_req_o       = sel ? m1_req_i : m0_req_i;
  assign m0_req_ready_o = !tag_full && dn_req_ready_i && !sel;
  assign m1_req_ready_o = !tag_full && dn_req_ready_i && sel;
  assign dn_xfer        = dn_req_valid_o && dn_req_ready_i;

  always_ff @(posedge cpu_clk_i) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      grant_q  <= 1'b0;
      last_q   <= 1'b1;
    end else begin
      locked_q <= dn_req_valid_o && !dn_req_ready_i;
      grant_q  <= sel;
      if (dn_xfer) begin
        last_q <= sel;
      end
    end
  end

  // ----------------------------------------------------------
  // response return to owner at queue head
  // ----------------------------------------------------------
  assign m0_rsp_o       = dn_rsp_i;
  assign m1_rsp_o       = dn_rsp_i;
  assign m0_rsp_valid_o = dn_rsp_valid_i && !tag_empty && !owner;
  assign m1_rsp_valid_o = dn_rsp_valid_i && !tag_empty && owner;
  assign dn_rsp_ready_o = !tag_empty && (owner ? m1_rsp_ready_i : m0_rsp_ready_i);

  tag_fifo owner_fifo_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .push_i     (dn_xfer),
    .push_tag_i (sel),
    .pop_i      (dn_rsp_valid_i && dn_rsp_ready_o),
    .head_tag_o (owner),
    .empty_o    (tag_empty),
    .full_o     (tag_full)
  );

endmodule

`default_nettype wire

//--- src/reg_downsizer.sv
`default_nettype none

module reg_downsizer (
  input  logic                     cpu_clk_i,
  input  logic                     rst_i,
  input  logic                     up_req_valid_i,
  input  fabric_pkg::fab_req_t     up_req_i,
  output logic                     up_req_ready_o,
  output logic                     up_rsp_valid_o,
  output fabric_pkg::fab_rsp_t     up_rsp_o,
  input  logic                     up_rsp_ready_i,
  output logic                     reg_req_valid_o,
  output fabric_pkg::reg_req_t     reg_req_o,
  input  logic                     reg_req_ready_i,
  input  logic                     reg_rsp_valid_i,
  input  fabric_pkg::narrow_rsp_t  reg_rsp_i,
  output logic                     reg_rsp_ready_o
);
  import fabric_pkg::*;

  logic lane_sel;
  logic head_lane;
  logic tag_empty;
  logic tag_full;

  assign lane_sel = up_req_i.addr[LANE_BIT];

  // ----------------------------------------------------------
  // request: pick lane, trim address
  // ----------------------------------------------------------
  assign reg_req_valid_o = up_req_valid_i && !tag_full;
  assign up_req_ready_o  = reg_req_ready_i && !tag_full;

  always_comb begin
    reg_req_o.addr  = up_req_i.addr[REG_ADDR_W-1:0];
    reg_req_o.write = up_req_i.write;
    reg_req_o.wdata = up_req_i.wdata.lane[lane_sel];
    if (lane_sel) begin
      reg_req_o.wstrb = up_req_i.wstrb[STRB_W-1 -: LANE_STRB_W];
    end else begin
      reg_req_o.wstrb = up_req_i.wstrb[LANE_STRB_W-1:0];
    end
  end

  // ----------------------------------------------------------
  // response: back into the recorded lane
  // ----------------------------------------------------------
  assign up_rsp_valid_o  = reg_rsp_valid_i && !tag_empty;
  assign reg_rsp_ready_o = up_rsp_ready_i && !tag_empty;

  always_comb begin
    up_rsp_o.rdata.word            = '0;
    up_rsp_o.rdata.lane[head_lane] = reg_rsp_i.rdata;
    up_rsp_o.err                   = reg_rsp_i.err;
  end

  tag_fifo lane_fifo_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .push_i     (reg_req_valid_o && reg_req_ready_i),
    .push_tag_i (lane_sel),
    .pop_i      (up_rsp_valid_o && up_rsp_ready_i),
    .head_tag_o (head_lane),
    .empty_o    (tag_empty),
    .full_o     (tag_full)
  );

endmodule

`default_nettype wire

//--- src/soc_fabric_top.sv
`default_nettype none

module soc_fabric_top (
  input  logic                     cpu_clk_i,
  input  logic                     rst_i,
  input  logic                     cpu_req_valid_i,
  input  fabric_pkg::fab_req_t     cpu_req_i,
  output logic                     cpu_req_ready_o,
  output logic                     cpu_rsp_valid_o,
  output fabric_pkg::fab_rsp_t     cpu_rsp_o,
  input  logic                     cpu_rsp_ready_i,
  input  logic                     dma_req_valid_i,
  input  fabric_pkg::narrow_req_t  dma_req_i,
  output logic                     dma_req_ready_o,
  output logic                     dma_rsp_valid_o,
  output fabric_pkg::narrow_rsp_t  dma_rsp_o,
  input  logic                     dma_rsp_ready_i,
  output logic                     mem_req_valid_o,
  output fabric_pkg::fab_req_t     mem_req_o,
  input  logic                     mem_req_ready_i,
  input  logic                     mem_rsp_valid_i,
  input  fabric_pkg::fab_rsp_t     mem_rsp_i,
  output logic                     mem_rsp_ready_o,
  output logic                     reg_req_valid_o,
  output fabric_pkg::reg_req_t     reg_req_o,
  input  logic                     reg_req_ready_i,
  input  logic                     reg_rsp_valid_i,
  input  fabric_pkg::narrow_rsp_t  reg_rsp_i,
  output logic                     reg_rsp_ready_o
);
  import fabric_pkg::*;

  // upsizer to arbiter port 1
  logic     dma_fab_req_valid;
  fab_req_t dma_fab_req;
  logic     dma_fab_req_ready;
  logic     dma_fab_rsp_valid;
  fab_rsp_t dma_fab_rsp;
  logic     dma_fab_rsp_ready;

  // arbiter to router
  logic     arb_req_valid;
  fab_req_t arb_req;
  logic     arb_req_ready;
  logic     arb_rsp_valid;
  fab_rsp_t arb_rsp;
  logic     arb_rsp_ready;

  // router to downsizer
  logic     rfab_req_valid;
  fab_req_t rfab_req;
  logic     rfab_req_ready;
  logic     rfab_rsp_valid;
  fab_rsp_t rfab_rsp;
  logic     rfab_rsp_ready;

  dma_upsizer upsizer_i (
    .cpu_clk_i, .rst_i,
    .dma_req_valid_i, .dma_req_i, .dma_req_ready_o,
    .dma_rsp_valid_o, .dma_rsp_o, .dma_rsp_ready_i,
    .up_req_valid_o (dma_fab_req_valid),
    .up_req_o       (dma_fab_req),
    .up_req_ready_i (dma_fab_req_ready),
    .up_rsp_valid_i (dma_fab_rsp_valid),
    .up_rsp_i       (dma_fab_rsp),
    .up_rsp_ready_o (dma_fab_rsp_ready)
  );

  // cpu on port 0, dma on port 1
  master_arbiter arbiter_i (
    .cpu_clk_i, .rst_i,
    .m0_req_valid_i (cpu_req_valid_i),
    .m0_req_i       (cpu_req_i),
    .m0_req_ready_o (cpu_req_ready_o),
    .m0_rsp_valid_o (cpu_rsp_valid_o),
    .m0_rsp_o       (cpu_rsp_o),
    .m0_rsp_ready_i (cpu_rsp_ready_i),
    .m1_req_valid_i (dma_fab_req_valid),
    .m1_req_i       (dma_fab_req),
    .m1_req_ready_o (dma_fab_req_ready),
    .m1_rsp_valid_o (dma_fab_rsp_valid),
    .m1_rsp_o       (dma_fab_rsp),
    .m1_rsp_ready_i (dma_fab_rsp_ready),
    .dn_req_valid_o (arb_req_valid),
    .dn_req_o       (arb_req),
    .dn_req_ready_i (arb_req_ready),
    .dn_rsp_valid_i (arb_rsp_valid),
    .dn_rsp_i       (arb_rsp),
    .dn_rsp_ready_o (arb_rsp_ready)
  );

  target_router router_i (
    .cpu_clk_i, .rst_i,
    .up_req_valid_i  (arb_req_valid),
    .up_req_i        (arb_req),
    .up_req_ready_o  (arb_req_ready),
    .up_rsp_valid_o  (arb_rsp_valid),
    .up_rsp_o        (arb_rsp),
    .up_rsp_ready_i  (arb_rsp_ready),
    .mem_req_valid_o, .mem_req_o, .mem_req_ready_i,
    .mem_rsp_valid_i, .mem_rsp_i, .mem_rsp_ready_o,
    .reg_req_valid_o (rfab_req_valid),
    .reg_req_o       (rfab_req),
    .reg_req_ready_i (rfab_req_ready),
    .reg_rsp_valid_i (rfab_rsp_valid),
    .reg_rsp_i       (rfab_rsp),
    .reg_rsp_ready_o (rfab_rsp_ready)
  );

  reg_downsizer downsizer_i (
    .cpu_clk_i, .rst_i,
    .up_req_valid_i (rfab_req_valid),
    .up_req_i       (rfab_req),
    .up_req_ready_o (rfab_req_ready),
    .up_rsp_valid_o (rfab_rsp_valid),
    .up_rsp_o       (rfab_rsp),
    .up_rsp_ready_i (rfab_rsp_ready),
    .reg_req_valid_o, .reg_req_o, .reg_req_ready_i,
    .reg_rsp_valid_i, .reg_rsp_i, .reg_rsp_ready_o
  );

endmodule

`default_nettype wire

//--- src/tag_fifo.sv
`default_nettype none

module tag_fifo (
  input  logic cpu_clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  logic push_tag_i,
  input  logic pop_i,
  output logic head_tag_o,
  output logic empty_o,
  output logic full_o
);
  import fabric_pkg::*;

  logic                 tags [MAX_OUTSTANDING];
  logic [TAG_PTR_W-1:0] rd_ptr;
  logic [TAG_PTR_W-1:0] wr_ptr;
  logic [TAG_CNT_W-1:0] count;

  assign head_tag_o = tags[rd_ptr];
  assign empty_o    = (count == '0);
  assign full_o     = (count == TAG_CNT_W'(MAX_OUTSTANDING));

  // tag storage
  always_ff @(posedge cpu_clk_i) begin
    if (push_i) begin
      tags[wr_ptr] <= push_tag_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == TAG_PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == TAG_PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/target_router.sv
`default_nettype none

module target_router (
  input  logic                  cpu_clk_i,
  input  logic                  rst_i,
  input  logic                  up_req_valid_i,
  input  fabric_pkg::fab_req_t  up_req_i,
  output logic                  up_req_ready_o,
  output logic                  up_rsp_valid_o,
  output fabric_pkg::fab_rsp_t  up_rsp_o,
  input  logic                  up_rsp_ready_i,
  output logic                  mem_req_valid_o,
  output fabric_pkg::fab_req_t  mem_req_o,
  input  logic                  mem_req_ready_i,
  input  logic                  mem_rsp_valid_i,
  input  fabric_pkg::fab_rsp_t  mem_rsp_i,
  output logic                  mem_rsp_ready_o,
  output logic                  reg_req_valid_o,
  output fabric_pkg::fab_req_t  reg_req_o,
  input  logic                  reg_req_ready_i,
  input  logic                  reg_rsp_valid_i,
  input  fabric_pkg::fab_rsp_t  reg_rsp_i,
  output logic                  reg_rsp_ready_o
);
  import fabric_pkg::*;

  logic is_reg;
  logic head_tgt;
  logic tag_empty;
  logic tag_full;

  // address decode
  assign is_reg = (up_req_i.addr[ADDR_W-1 -: REGION_W] == REG_REGION);

  // request steering, payload goes to both
  assign mem_req_o       = up_req_i;
  assign reg_req_o       = up_req_i;
  assign mem_req_valid_o = up_req_valid_i && !tag_full && !is_reg;
  assign reg_req_valid_o = up_req_valid_i && !tag_full && is_reg;
  assign up_req_ready_o  = !tag_full && (is_reg ? reg_req_ready_i : mem_req_ready_i);

  // only the target at the queue head may answer
  assign up_rsp_valid_o  = !tag_empty && (head_tgt ? reg_rsp_valid_i : mem_rsp_valid_i);
  assign up_rsp_o        = head_tgt ? reg_rsp_i : mem_rsp_i;
  assign mem_rsp_ready_o = !tag_empty && !head_tgt && up_rsp_ready_i;
  assign reg_rsp_ready_o = !tag_empty && head_tgt && up_rsp_ready_i;

  tag_fifo target_fifo_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .push_i     (up_req_valid_i && up_req_ready_o),
    .push_tag_i (is_reg),
    .pop_i      (up_rsp_valid_o && up_rsp_ready_i),
    .head_tag_o (head_tgt),
    .empty_o    (tag_empty),
    .full_o     (tag_full)
  );

endmodule

`default_nettype wire
